//--- common/matmul_settings.svh
// Design-wide sizes and widths for the 3x3 matrix-multiply datapath
// Shared by the package and every block that needs a count
`ifndef MATMUL_SETTINGS_SVH
`define MATMUL_SETTINGS_SVH

// ------------------------------
// Matrix shape
// ------------------------------
`define MM_ROWS   3  // Rows of A and C
`define MM_INNER  3  // Columns of A, rows of B
`define MM_COLS   3  // Columns of B and C

// Operand banks per matrix
`define MM_BANKS  3

// ------------------------------
// Data widths
// ------------------------------
`define MM_DATA_W 16 // Element width of A and B

// Full product width plus two guard bits for the 3-term sum
`define MM_ACC_W  (2 * `MM_DATA_W + 2)

`endif

//--- common/matmul_pkg.sv
// Shared types for elements, sums, bank addresses and PE indexing
`default_nettype none

`include "matmul_settings.svh"

package matmul_pkg;

  // ------------------------------
  // Data
  // ------------------------------
  typedef logic [`MM_DATA_W-1:0] elem_t; // A or B element
  typedef logic [`MM_ACC_W-1:0]  acc_t;  // One C sum

  // ------------------------------
  // Addresses
  // ------------------------------
  // One A bank holds one row of A
  typedef logic [$clog2((`MM_ROWS / `MM_BANKS) * `MM_INNER)-1:0] a_addr_t;

  // One B bank holds one column of B
  typedef logic [$clog2(`MM_INNER * (`MM_COLS / `MM_BANKS))-1:0] b_addr_t;

  // Result memory holds all of C
  typedef logic [$clog2(`MM_ROWS * `MM_COLS)-1:0] c_addr_t;

  // ------------------------------
  // PE grid
  // ------------------------------
  // Row-major flat index, row * cols + col
  typedef logic [$clog2(`MM_ROWS * `MM_COLS)-1:0] pe_idx_t;

  typedef logic [`MM_ROWS*`MM_COLS-1:0] pe_mask_t; // One bit per PE

endpackage

`default_nettype wire

//--- common/bank_port_if.sv
// One memory port: enable, write, address, write data and read data
`timescale 1ns/1ps
`default_nettype none

interface bank_port_if #(
  parameter type addr_t = logic [1:0], // Word address
  parameter type data_t = logic [15:0] // Stored word
);

  logic  en;    // Access strobe
  logic  we;    // Write when set, read otherwise
  addr_t addr;
  data_t wdata;
  data_t rdata; // Valid the cycle after a read

  // Side that issues accesses
  modport host (
    output en, we, addr, wdata,
    input  rdata
  );

  // Memory side
  modport mem (
    input  en, we, addr, wdata,
    output rdata
  );

  // Consumer of read data only, e.g. the PE grid
  modport reader (
    input rdata
  );

endinterface

`default_nettype wire

//--- src/dp_bram.sv
// Synchronous memory with one read/write port and one separate read port
`timescale 1ns/1ps
`default_nettype none

module dp_bram #(
  parameter type addr_t = logic [1:0],  // Address type, sets the depth
  parameter type data_t = logic [15:0]  // Word type
) (
  input  wire logic    clk,
  bank_port_if.mem     wr_port,  // Read/write port
  input  wire logic    rd_en,    // Separate read port strobe
  input  wire addr_t   rd_addr,
  output data_t        rd_data   // Registered, holds when idle
);

  // Every address value maps to a word
  localparam int DEPTH = 2 ** $bits(addr_t);

  data_t mem [DEPTH]; // Storage array

  // ------------------------------
  // Read/write port
  // ------------------------------
  // Write on en+we, read on en alone
  // rdata only changes on a read edge
  always_ff @(posedge clk)
  begin
    if (wr_port.en)
    begin
      if (wr_port.we)
      begin
        mem[wr_port.addr] <= wr_port.wdata; // Write takes effect this edge
      end
      else
      begin
        wr_port.rdata <= mem[wr_port.addr]; // Data out next cycle
      end
    end
  end

  // ------------------------------
  // Read-only port
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      rd_data <= mem[rd_addr]; // One-cycle read latency
    end
  end

  // Same-address write and read on one edge returns the old word
  // on rd_data, since both sides sample mem before the update

endmodule

`default_nettype wire

//--- pe_array/mac_pe.sv
// Single multiply-accumulate element with registered sum and done pulse
`timescale 1ns/1ps
`default_nettype none

module mac_pe (
  input  wire logic             clk,
  input  wire logic             clr_n,
  input  wire logic             start,  // First step, load instead of add
  input  wire logic             valid,  // Operands present this edge
  input  wire logic             last,   // Final step of the product
  input  wire matmul_pkg::elem_t a,
  input  wire matmul_pkg::elem_t b,
  output matmul_pkg::acc_t      sum,    // Running sum
  output logic                  done    // One cycle after the last step
);

  import matmul_pkg::*;

  acc_t prod; // Full product, widened to the sum

  // Unsigned product, zero-extended before the multiply
  assign prod = acc_t'(a) * acc_t'(b);

  // ------------------------------
  // Accumulator
  // ------------------------------
  always_ff @(posedge clk or negedge clr_n)
  begin
    if (!clr_n)
    begin
      sum <= '0;
    end
    else if (valid)
    begin
      if (start)
      begin
        sum <= prod;       // Fresh product, drops the old result
      end
      else
      begin
        sum <= sum + prod; // Guard bits absorb the carries
      end
    end
    // Held otherwise, stays put until the next start
  end

  // ------------------------------
  // Completion
  // ------------------------------
  always_ff @(posedge clk or negedge clr_n)
  begin
    if (!clr_n)
    begin
      done <= 1'b0;
    end
    else
    begin
      done <= valid & last; // Pulse, high for one cycle only
    end
  end

endmodule

`default_nettype wire

//--- pe_array/pe_array.sv
// 3x3 grid of MAC elements with bank-to-element routing
// Sums and done bits gathered in row-major order
`timescale 1ns/1ps
`default_nettype none

`include "matmul_settings.svh"

module pe_array (
  input  wire logic              clk,
  input  wire logic              clr_n,
  input  wire logic              start,   // Broadcast to every element
  input  wire logic              valid,
  input  wire logic              last,
  bank_port_if.reader            a_bank0, // A rows 0, 3, ...
  bank_port_if.reader            a_bank1,
  bank_port_if.reader            a_bank2,
  bank_port_if.reader            b_bank0, // B columns 0, 3, ...
  bank_port_if.reader            b_bank1,
  bank_port_if.reader            b_bank2,
  output matmul_pkg::acc_t       sums [`MM_ROWS*`MM_COLS], // Row-major
  output matmul_pkg::pe_mask_t   done_mask
);

  import matmul_pkg::*;

  elem_t a_rd [`MM_BANKS]; // Read data per A bank
  elem_t b_rd [`MM_BANKS]; // Read data per B bank

  // ------------------------------
  // Bank read data
  // ------------------------------
  assign a_rd[0] = a_bank0.rdata;
  assign a_rd[1] = a_bank1.rdata;
  assign a_rd[2] = a_bank2.rdata;

  assign b_rd[0] = b_bank0.rdata;
  assign b_rd[1] = b_bank1.rdata;
  assign b_rd[2] = b_bank2.rdata;

  // ------------------------------
  // Element grid
  // ------------------------------
  // Element (r, c) builds C[r][c]
  // It takes A[r][k] from A bank r mod 3 and B[k][c] from B bank c mod 3
  for (genvar r = 0; r < `MM_ROWS; r++)
  begin : g_row
    for (genvar c = 0; c < `MM_COLS; c++)
    begin : g_col
      mac_pe u_pe (
        .clk   (clk),
        .clr_n (clr_n),
        .start (start),
        .valid (valid),
        .last  (last),
        .a     (a_rd[r % `MM_BANKS]),             // Row operand
        .b     (b_rd[c % `MM_BANKS]),             // Column operand
        .sum   (sums[r * `MM_COLS + c]),          // Flat row-major slot
        .done  (done_mask[r * `MM_COLS + c])
      );
    end
  end

endmodule

`default_nettype wire

//--- result_buffer/result_buffer.sv
// Nine-entry snapshot of the PE sums with clear, valid flag
// and drain selection toward the result memory
`timescale 1ns/1ps
`default_nettype none

`include "matmul_settings.svh"

module result_buffer (
  input  wire logic                clk,
  input  wire logic                clr_n,
  input  wire logic                capture,    // Take all sums next edge
  input  wire logic                clear,      // Zero entries, wins over capture
  input  wire logic                c_wr,       // Drain write this edge
  input  wire matmul_pkg::pe_idx_t drain_idx,  // Entry being drained
  input  wire matmul_pkg::acc_t    sums [`MM_ROWS*`MM_COLS],
  output matmul_pkg::acc_t         drain_data, // Selected entry, combinational
  output logic                     valid       // Snapshot not yet fully drained
);

  import matmul_pkg::*;

  localparam int N_PE = `MM_ROWS * `MM_COLS;

  // Index of the final entry, its write ends the drain
  localparam pe_idx_t LAST_IDX = pe_idx_t'(N_PE - 1);

  acc_t entry [N_PE]; // Captured sums

  logic last_wr; // Final drain write on this edge

  assign last_wr = valid & c_wr & (drain_idx == LAST_IDX);

  // ------------------------------
  // Snapshot and valid flag
  // ------------------------------
  always_ff @(posedge clk or negedge clr_n)
  begin
    if (!clr_n)
    begin
      entry <= '{default: '0};
      valid <= 1'b0;
    end
    else if (clear)
    begin
      entry <= '{default: '0}; // Later drain writes zeros
      valid <= 1'b0;
    end
    else if (capture)
    begin
      entry <= sums;           // All nine at once
      valid <= 1'b1;
    end
    else if (last_wr)
    begin
      valid <= 1'b0;           // Entries kept, flag only
    end
  end

  // ------------------------------
  // Drain select
  // ------------------------------
  // Indices past the grid read as zero
  always_comb
  begin
    drain_data = '0;
    if (drain_idx < pe_idx_t'(N_PE))
    begin
      drain_data = entry[drain_idx];
    end
  end

endmodule

`default_nettype wire

//--- src/matmul_datapath.sv
// Top level: operand banks, PE grid, result buffer and result memory
`timescale 1ns/1ps
`default_nettype none

`include "matmul_settings.svh"

module matmul_datapath (
  input  wire logic                                  clk,
  input  wire logic                                  clr_n,

  // A operand banks, one slice per bank
  input  wire logic [`MM_BANKS-1:0]                  a_en,
  input  wire logic [`MM_BANKS-1:0]                  a_we,
  input  wire matmul_pkg::a_addr_t [`MM_BANKS-1:0]   a_addr,
  input  wire matmul_pkg::elem_t [`MM_BANKS-1:0]     a_din,

  // B operand banks
  input  wire logic [`MM_BANKS-1:0]                  b_en,
  input  wire logic [`MM_BANKS-1:0]                  b_we,
  input  wire matmul_pkg::b_addr_t [`MM_BANKS-1:0]   b_addr,
  input  wire matmul_pkg::elem_t [`MM_BANKS-1:0]     b_din,

  // PE strobes, broadcast
  input  wire logic                                  pe_start,
  input  wire logic                                  pe_valid, // One cycle after bank reads
  input  wire logic                                  pe_last,

  // Buffer control
  input  wire logic                                  capture,
  input  wire logic                                  buf_clear,

  // Drain into the result memory
  input  wire logic                                  c_wr,
  input  wire matmul_pkg::c_addr_t                   c_addr,
  input  wire matmul_pkg::pe_idx_t                   drain_idx,

  // External read-back
  input  wire logic                                  rd_en,
  input  wire matmul_pkg::c_addr_t                   rd_addr,
  output matmul_pkg::acc_t                           dout_c,

  // Status
  output matmul_pkg::pe_mask_t                       pe_done,
  output logic                                       buf_valid
);

  import matmul_pkg::*;

  acc_t pe_sums [`MM_ROWS*`MM_COLS]; // Live PE sums
  acc_t drain_data;                  // Buffer entry on its way to memory

  // ------------------------------
  // Operand banks
  // ------------------------------
  bank_port_if #(.addr_t(a_addr_t), .data_t(elem_t)) a_if [`MM_BANKS] ();
  bank_port_if #(.addr_t(b_addr_t), .data_t(elem_t)) b_if [`MM_BANKS] ();

  for (genvar g = 0; g < `MM_BANKS; g++)
  begin : g_bank
    // Vector port slices onto each bank's port
    assign a_if[g].en    = a_en[g];
    assign a_if[g].we    = a_we[g];
    assign a_if[g].addr  = a_addr[g];
    assign a_if[g].wdata = a_din[g];

    assign b_if[g].en    = b_en[g];
    assign b_if[g].we    = b_we[g];
    assign b_if[g].addr  = b_addr[g];
    assign b_if[g].wdata = b_din[g];

    // Separate read port idle on operand banks
    dp_bram #(.addr_t(a_addr_t), .data_t(elem_t)) u_a_bank (
      .clk     (clk),
      .wr_port (a_if[g]),
      .rd_en   (1'b0),
      .rd_addr ('0),
      .rd_data ()
    );

    dp_bram #(.addr_t(b_addr_t), .data_t(elem_t)) u_b_bank (
      .clk     (clk),
      .wr_port (b_if[g]),
      .rd_en   (1'b0),
      .rd_addr ('0),
      .rd_data ()
    );
  end

  // ------------------------------
  // PE grid
  // ------------------------------
  pe_array u_pe_array (
    .clk       (clk),
    .clr_n     (clr_n),
    .start     (pe_start),
    .valid     (pe_valid),
    .last      (pe_last),
    .a_bank0   (a_if[0]),
    .a_bank1   (a_if[1]),
    .a_bank2   (a_if[2]),
    .b_bank0   (b_if[0]),
    .b_bank1   (b_if[1]),
    .b_bank2   (b_if[2]),
    .sums      (pe_sums),
    .done_mask (pe_done)
  );

  // ------------------------------
  // Result buffer
  // ------------------------------
  result_buffer u_result_buffer (
    .clk        (clk),
    .clr_n      (clr_n),
    .capture    (capture),
    .clear      (buf_clear),
    .c_wr       (c_wr),
    .drain_idx  (drain_idx),
    .sums       (pe_sums),
    .drain_data (drain_data),
    .valid      (buf_valid)
  );

  // ------------------------------
  // Result memory
  // ------------------------------
  // Write-only from the buffer, read back through rd_*
  bank_port_if #(.addr_t(c_addr_t), .data_t(acc_t)) c_if ();

  assign c_if.en    = c_wr;
  assign c_if.we    = c_wr;       // Never reads on this side
  assign c_if.addr  = c_addr;
  assign c_if.wdata = drain_data; // Same-edge write of the selected entry

  dp_bram #(.addr_t(c_addr_t), .data_t(acc_t)) u_c_mem (
    .clk     (clk),
    .wr_port (c_if),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (dout_c)  // One cycle after rd_en
  );

endmodule

`default_nettype wire

//--- verif/matmul_tb.sv
// Directed testbench for the matrix-multiply datapath
// Plays the controller: loads banks, runs products, drains and reads back C
`timescale 1ns/1ps
`default_nettype none

`include "matmul_settings.svh"

module matmul_tb;

  import matmul_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 60;                                   // Budget per test
  localparam int WATCHDOG_NS = NUM_TESTS * TEST_CYCLES * CLK_PERIOD;
  localparam int N_C         = `MM_ROWS * `MM_COLS;
  localparam pe_mask_t ALL_DONE = '1;

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic clk;
  logic clr_n;
  logic [`MM_BANKS-1:0] a_en, a_we, b_en, b_we;
  a_addr_t [`MM_BANKS-1:0] a_addr;
  b_addr_t [`MM_BANKS-1:0] b_addr;
  elem_t [`MM_BANKS-1:0] a_din, b_din;
  logic pe_start, pe_valid, pe_last;
  logic capture, buf_clear, c_wr, rd_en;
  c_addr_t c_addr, rd_addr;
  pe_idx_t drain_idx;
  acc_t dout_c;
  pe_mask_t pe_done;
  logic buf_valid;

  // Operands and expected product
  elem_t mat_a [`MM_ROWS][`MM_INNER];
  elem_t mat_b [`MM_INNER][`MM_COLS];
  acc_t ref_c [`MM_ROWS][`MM_COLS];

  int errors = 0;
  int checks = 0;
  int test_start_errors = 0;
  int tests_run = 0;

  matmul_datapath uut (
    .clk (clk), .clr_n (clr_n),
    .a_en (a_en), .a_we (a_we), .a_addr (a_addr), .a_din (a_din),
    .b_en (b_en), .b_we (b_we), .b_addr (b_addr), .b_din (b_din),
    .pe_start (pe_start), .pe_valid (pe_valid), .pe_last (pe_last),
    .capture (capture), .buf_clear (buf_clear),
    .c_wr (c_wr), .c_addr (c_addr), .drain_idx (drain_idx),
    .rd_en (rd_en), .rd_addr (rd_addr), .dout_c (dout_c),
    .pe_done (pe_done), .buf_valid (buf_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk; // 40 ns period

  // Watchdog sized from the test budget
  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #2; // Outputs settled and inputs change here
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  // Plain triple-loop product C = A * B
  task automatic compute_reference();
    for (int i = 0; i < `MM_ROWS; i++)
      for (int j = 0; j < `MM_COLS; j++)
      begin
        ref_c[i][j] = '0;
        for (int k = 0; k < `MM_INNER; k++)
          ref_c[i][j] += acc_t'(mat_a[i][k]) * acc_t'(mat_b[k][j]);
      end
  endtask

  task automatic randomize_matrices();
    for (int i = 0; i < 3; i++)
      for (int j = 0; j < 3; j++)
      begin
        mat_a[i][j] = elem_t'($urandom()); // Full 16-bit range
        mat_b[i][j] = elem_t'($urandom());
      end
    compute_reference();
  endtask

  // A row i to bank i, B column j to bank j, address k
  task automatic load_matrices();
    for (int k = 0; k < `MM_INNER; k++)
    begin
      a_en = '1;
      a_we = '1;
      b_en = '1;
      b_we = '1;
      for (int g = 0; g < `MM_BANKS; g++)
      begin
        a_addr[g] = a_addr_t'(k);
        a_din[g]  = mat_a[g][k];
        b_addr[g] = b_addr_t'(k);
        b_din[g]  = mat_b[k][g];
      end
      next_cycle();
    end
    a_en = '0;
    a_we = '0;
    b_en = '0;
    b_we = '0;
  endtask

  // Read step k while pe_valid covers step k-1
  task automatic run_product();
    for (int k = 0; k <= `MM_INNER; k++)
    begin
      a_en = (k < `MM_INNER) ? '1 : '0;
      b_en = (k < `MM_INNER) ? '1 : '0;
      for (int g = 0; g < `MM_BANKS; g++)
      begin
        a_addr[g] = a_addr_t'(k % `MM_INNER);
        b_addr[g] = b_addr_t'(k % `MM_INNER);
      end
      pe_valid = (k > 0);
      pe_start = (k == 1);
      pe_last  = (k == `MM_INNER);
      next_cycle();
      check_value("pe_done", pe_done, (k == `MM_INNER) ? ALL_DONE : '0); // Exact cycle
    end
    a_en = '0;
    b_en = '0;
    pe_valid = 1'b0;
    pe_start = 1'b0;
    pe_last  = 1'b0;
    next_cycle();
    check_value("pe_done", pe_done, '0); // One-cycle pulse
  endtask

  task automatic capture_and_drain(input bit clear_first);
    capture = 1'b1;
    next_cycle();
    capture = 1'b0;
    check_value("buf_valid", buf_valid, 1);
    if (clear_first)
    begin
      buf_clear = 1'b1;
      next_cycle();
      buf_clear = 1'b0;
      check_value("buf_valid", buf_valid, 0);
    end
    for (int n = 0; n < N_C; n++)
    begin
      c_wr      = 1'b1;
      c_addr    = c_addr_t'(n);
      drain_idx = pe_idx_t'(n);
      next_cycle();
      check_value("buf_valid", buf_valid, !clear_first && (n < N_C - 1)); // Drops after 8
    end
    c_wr = 1'b0;
  endtask

  task automatic read_result(input bit expect_zero);
    for (int n = 0; n < N_C; n++)
    begin
      rd_en   = 1'b1;
      rd_addr = c_addr_t'(n);
      next_cycle();
      check_value("dout_c", dout_c, expect_zero ? '0 : ref_c[n / `MM_COLS][n % `MM_COLS]);
    end
    rd_en = 1'b0;
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic reset_state_test();
    check_value("pe_done", pe_done, '0);
    check_value("buf_valid", buf_valid, 0);
    finish_test("reset state");
  endtask

  task automatic identity_product();
    for (int i = 0; i < 3; i++)
      for (int j = 0; j < 3; j++)
      begin
        mat_a[i][j] = (i == j) ? 16'd1 : 16'd0;
        mat_b[i][j] = elem_t'(16'h0101 * (i * 3 + j + 1)); // Distinct known words
        ref_c[i][j] = acc_t'(mat_b[i][j]);                  // Identity A, so C is B
      end
    load_matrices();
    run_product();
    capture_and_drain(0);
    read_result(0);
    finish_test("identity times B");
  endtask

  task automatic random_products();
    for (int p = 0; p < 5; p++)
    begin
      randomize_matrices();
      load_matrices();
      run_product();
      capture_and_drain(0);
      read_result(0);
    end
    finish_test("random products");
  endtask

  // Second result must not carry the first sum
  task automatic back_to_back_products();
    randomize_matrices();
    load_matrices();
    run_product();
    randomize_matrices();
    load_matrices();
    run_product();
    capture_and_drain(0);
    read_result(0);
    finish_test("back to back");
  endtask

  task automatic drain_valid_flag();
    randomize_matrices();
    load_matrices();
    run_product();
    capture_and_drain(0); // Flag checked per drain index
    next_cycle();
    check_value("buf_valid", buf_valid, 0); // Stays low once drained
    finish_test("drain valid flag");
  endtask

  task automatic clear_after_capture();
    randomize_matrices();
    load_matrices();
    run_product();
    capture_and_drain(1);
    read_result(1); // All zero after clear
    finish_test("clear after capture");
  endtask

  initial
  begin
    void'($urandom(34940)); // Seed once
    clk = 1'b0;
    clr_n = 1'b0;
    a_en = '0;
    a_we = '0;
    a_addr = '0;
    a_din = '0;
    b_en = '0;
    b_we = '0;
    b_addr = '0;
    b_din = '0;
    pe_start = 1'b0;
    pe_valid = 1'b0;
    pe_last = 1'b0;
    capture = 1'b0;
    buf_clear = 1'b0;
    c_wr = 1'b0;
    c_addr = '0;
    drain_idx = '0;
    rd_en = 1'b0;
    rd_addr = '0;
    repeat (2) @(posedge clk); // Reset for 2 cycles
    #2;
    clr_n = 1'b1;
    next_cycle();

    reset_state_test();
    identity_product();
    random_products();
    back_to_back_products();
    drain_valid_flag();
    clear_after_capture();

    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/matmul_pkg.sv
common/bank_port_if.sv
src/dp_bram.sv
pe_array/mac_pe.sv
pe_array/pe_array.sv
result_buffer/result_buffer.sv
src/matmul_datapath.sv
verif/matmul_tb.sv
